// File: compile.f
hw/tpm_pkg.sv
hw/tpm_locality_arbiter.sv
hw/tpm_sts_fsm.sv
hw/tpm_data_fifo.sv
hw/tpm_int_ctrl.sv
hw/tpm_reg_space.sv
hw/tpm_fifo_if.sv
bench/tpm_checker.sv
bench/tb_tpm.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tpm
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_tpm.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the TPM FIFO interface
// Clock, reset, LCG, bus read and write tasks, executor model
// Scenarios for identity, locality, command, response and interrupts
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_tpm;

	logic                 clock;
	logic                 reset_n;
	tpm_pkg::bus_req_t    bus_i;
	tpm_pkg::byte_t       rd_data_o;
	tpm_pkg::loc_onehot_t locality_o;
	logic                 pirq_n_o;
	logic                 exec_start_o;
	logic [31:0]          cmd_size_o;
	logic [5:0]           cmd_addr_i;
	tpm_pkg::byte_t       cmd_byte_o;
	logic                 rsp_wr_i;
	tpm_pkg::byte_t       rsp_byte_i;
	logic                 exec_done_i;

	int unsigned          mismatches;
	int unsigned          timeouts;
	logic [31:0]          lcg_state;
	tpm_pkg::byte_t       cmd_bytes [64];  // Expected command, header included
	int                   cmd_len;

	tpm_fifo_if #(.CMD_DEPTH(64), .RSP_DEPTH(64)) dut0 (
		.clock(clock), .reset_n(reset_n), .bus_i(bus_i), .rd_data_o(rd_data_o),
		.locality_o(locality_o), .pirq_n_o(pirq_n_o), .exec_start_o(exec_start_o),
		.cmd_size_o(cmd_size_o), .cmd_addr_i(cmd_addr_i), .cmd_byte_o(cmd_byte_o),
		.rsp_wr_i(rsp_wr_i), .rsp_byte_i(rsp_byte_i), .exec_done_i(exec_done_i)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_byte(input string name, input tpm_pkg::byte_t got,
		input tpm_pkg::byte_t exp);
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	// One strobe per byte, released on the next falling edge
	task automatic bus_write(input tpm_pkg::loc_t loc, input tpm_pkg::reg_off_t off,
		input tpm_pkg::byte_t data);
		@(negedge clock);
		bus_i = '{strobe: 1'b1, dir: 1'b0, loc: loc, off: off, wdata: data};
		@(negedge clock);
		bus_i.strobe = 1'b0;
	endtask

	task automatic read_check(input tpm_pkg::loc_t loc, input tpm_pkg::reg_off_t off,
		input tpm_pkg::byte_t exp, input string name);
		@(negedge clock);
		bus_i = '{strobe: 1'b1, dir: 1'b1, loc: loc, off: off, wdata: 8'h00};
		@(negedge clock);
		bus_i.strobe = 1'b0;
		check_byte(name, rd_data_o, exp);   // Registered on the edge in between
	endtask

	task automatic wait_locality(input tpm_pkg::loc_onehot_t exp);
		int n;
		n = 0;
		while ((locality_o !== exp) && (n < 20))
		begin
			@(negedge clock);
			n++;
		end
		if (locality_o !== exp)
		begin
			timeouts++;
			$display("Timeout waiting for locality_o to become 0x%02h", exp);
		end
	endtask

	task automatic wait_exec_start();
		int n;
		n = 0;
		while ((exec_start_o !== 1'b1) && (n < 20))
		begin
			@(negedge clock);
			n++;
		end
		if (exec_start_o !== 1'b1)
		begin
			timeouts++;
			$display("Timeout waiting for the executor start pulse");
		end
	endtask

	task automatic wait_pirq(input logic level);
		int n;
		n = 0;
		while ((pirq_n_o !== level) && (n < 20))
		begin
			@(negedge clock);
			n++;
		end
		if (pirq_n_o !== level)
		begin
			timeouts++;
			$display("Timeout waiting for pirq_n_o to go to %0b", level);
		end
	endtask

	// Executor model, reads the command and answers with its inverse
	task automatic run_executor(input int len);
		tpm_pkg::byte_t got;
		wait_exec_start();
		assert (cmd_size_o == 32'(len))
		else
		begin
			mismatches++;
			$display("MISMATCH cmd_size_o got 0x%08h expected 0x%08h", cmd_size_o, len);
		end
		for (int i = 0; i < len; i++)
		begin
			@(negedge clock);
			rsp_wr_i   = 1'b0;
			cmd_addr_i = 6'(i);
			@(negedge clock);
			got = cmd_byte_o;
			check_byte("cmd_byte_o", got, cmd_bytes[i]);
			rsp_wr_i   = 1'b1;
			rsp_byte_i = ~got;
		end
		@(negedge clock);
		rsp_wr_i    = 1'b0;
		exec_done_i = 1'b1;
		@(negedge clock);
		exec_done_i = 1'b0;
	endtask

	// Command from locality 2, header tag then big-endian size
	task automatic send_command(input int len);
		cmd_bytes[0] = 8'h80;
		cmd_bytes[1] = 8'h01;
		for (int i = 2; i < 6; i++)
			cmd_bytes[i] = 8'(len >> (8 * (5 - i)));
		for (int i = 6; i < len; i++)
		begin
			lcg_state    = lcg_next(lcg_state);
			cmd_bytes[i] = lcg_state[23:16];
		end
		bus_write(3'd2, tpm_pkg::OFF_STS, 8'h40);     // Completion drops to Idle first
		bus_write(3'd2, tpm_pkg::OFF_STS, 8'h40);
		read_check(3'd2, tpm_pkg::OFF_STS, 8'hC0, "STS commandReady");
		for (int i = 0; i < len; i++)
		begin
			bus_write(3'd2, tpm_pkg::OFF_FIFO, cmd_bytes[i]);
			read_check(3'd2, tpm_pkg::OFF_STS, (i == len - 1) ? 8'h80 : 8'h88, "STS Expect");
		end
		bus_write(3'd2, tpm_pkg::OFF_STS, 8'h20);     // tpmGo
		run_executor(len);
	endtask

	task automatic read_response(input int len);
		tpm_pkg::byte_t exp;
		read_check(3'd2, tpm_pkg::OFF_STS, 8'h90, "STS dataAvail");
		for (int i = 0; i < len; i++)
		begin
			exp = ~cmd_bytes[i];
			read_check(3'd2, tpm_pkg::OFF_FIFO, exp, "FIFO");
		end
		read_check(3'd2, tpm_pkg::OFF_STS, 8'h80, "STS dataAvail");   // Drained
	endtask

	initial
	begin
		mismatches  = 0;
		timeouts    = 0;
		lcg_state   = 32'hcd19;
		reset_n     = 1'b0;
		bus_i       = '0;
		cmd_addr_i  = '0;
		rsp_wr_i    = 1'b0;
		rsp_byte_i  = '0;
		exec_done_i = 1'b0;
		repeat (4) @(negedge clock);
		reset_n = 1'b1;

		check_byte("pirq_n_o", {7'h00, pirq_n_o}, 8'h01);
		check_byte("exec_start_o", {7'h00, exec_start_o}, 8'h00);
		check_byte("locality_o", {3'b000, locality_o}, 8'h00);
		check_byte("rd_data_o", rd_data_o, 8'hFF);
		read_check(3'd0, tpm_pkg::OFF_STS, 8'hFF, "STS no locality");

		// Grant locality 0, identity is visible from there
		bus_write(3'd0, tpm_pkg::OFF_ACCESS, 8'h02);
		wait_locality(5'b00001);
		read_check(3'd0, tpm_pkg::OFF_ACCESS, 8'hA1, "ACCESS");
		read_check(3'd1, tpm_pkg::OFF_STS, 8'hFF, "STS other locality");
		read_check(3'd0, tpm_pkg::OFF_DID_VID, 8'h37, "DID_VID byte 0");
		read_check(3'd0, tpm_pkg::OFF_DID_VID + 12'd1, 8'h30, "DID_VID byte 1");
		read_check(3'd0, tpm_pkg::OFF_DID_VID + 12'd2, 8'h54, "DID_VID byte 2");
		read_check(3'd0, tpm_pkg::OFF_DID_VID + 12'd3, 8'h56, "DID_VID byte 3");
		read_check(3'd0, tpm_pkg::OFF_RID, 8'hFF, "RID");

		// Seize from locality 2
		bus_write(3'd2, tpm_pkg::OFF_ACCESS, 8'h08);
		wait_locality(5'b00100);
		read_check(3'd0, tpm_pkg::OFF_ACCESS, 8'h91, "ACCESS beenSeized");
		bus_write(3'd0, tpm_pkg::OFF_ACCESS, 8'h10);
		read_check(3'd0, tpm_pkg::OFF_ACCESS, 8'h81, "ACCESS beenSeized");

		// Interrupts off
		lcg_state = lcg_next(lcg_state);
		cmd_len   = 10 + (int'(lcg_state[23:16]) % 31);
		send_command(cmd_len);
		read_response(cmd_len);
		read_check(3'd2, tpm_pkg::OFF_INT_STATUS, 8'h00, "INT_STATUS");
		check_byte("pirq_n_o", {7'h00, pirq_n_o}, 8'h01);

		// Global and dataAvail enables on
		bus_write(3'd2, tpm_pkg::OFF_INT_ENABLE, 8'h01);
		bus_write(3'd2, tpm_pkg::OFF_INT_ENABLE + 12'd3, 8'h80);
		lcg_state = lcg_next(lcg_state);
		cmd_len   = 10 + (int'(lcg_state[23:16]) % 31);
		send_command(cmd_len);
		wait_pirq(1'b0);
		read_check(3'd2, tpm_pkg::OFF_INT_STATUS, 8'h01, "INT_STATUS");
		bus_write(3'd2, tpm_pkg::OFF_INT_STATUS, 8'h01);
		check_byte("pirq_n_o", {7'h00, pirq_n_o}, 8'h01);
		read_response(cmd_len);

		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut0.chk0.fail_count);
		if ((mismatches + timeouts + dut0.chk0.fail_count) == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tpm_checker.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the TPM FIFO interface top level
// Start pulse width, locality ownership and handover, PIRQ while
// globally disabled, gated reads
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_checker
(
	input logic                 clock,
	input logic                 reset_n,
	input tpm_pkg::bus_req_t    bus_i,
	input tpm_pkg::byte_t       rd_data_i,
	input tpm_pkg::loc_onehot_t locality_i,
	input logic                 pirq_n_i,
	input logic                 exec_start_i,
	input logic                 active_valid_i,
	input tpm_pkg::loc_t        active_loc_i,
	input logic                 gie_i         // Global interrupt enable
);

	int unsigned fail_count = 0;

	a_start_pulse: assert property (@(posedge clock) disable iff (!reset_n)
		exec_start_i |=> !exec_start_i)
		else
		begin
			fail_count++;
			$error("exec_start_o high for more than one cycle");
		end

	// At most one owner and never a direct handover
	a_loc_onehot: assert property (@(posedge clock) disable iff (!reset_n)
		$onehot0(locality_i) && ($stable(locality_i) || (locality_i == '0) ||
		($past(locality_i) == '0)))
		else
		begin
			fail_count++;
			$error("locality_o not one-hot or changed owner without a free cycle");
		end

	// Globally disabled, PIRQ cannot fall
	a_pirq_idle: assert property (@(posedge clock) disable iff (!reset_n)
		(pirq_n_i && !gie_i) |=> pirq_n_i)
		else
		begin
			fail_count++;
			$error("pirq_n_o fell while interrupts were globally disabled");
		end

	a_gated_read: assert property (@(posedge clock) disable iff (!reset_n)
		(bus_i.strobe && bus_i.dir && (bus_i.off != 12'h000) &&
		!(active_valid_i && (bus_i.loc == active_loc_i))) |=> (rd_data_i == 8'hFF))
		else
		begin
			fail_count++;
			$error("read from an inactive locality returned data");
		end

endmodule

bind tpm_fifo_if tpm_checker chk0 (
	.clock(clock), .reset_n(reset_n), .bus_i(bus_i), .rd_data_i(rd_data_o),
	.locality_i(locality_o), .pirq_n_i(pirq_n_o), .exec_start_i(exec_start_o),
	.active_valid_i(active_valid), .active_loc_i(active_loc),
	.gie_i(u_int_ctrl.gie_q)
);

`default_nettype wire

// File: hw/tpm_fifo_if.sv
////////////////////////////////////////////////////////////////////////////
// TPM 2.0 FIFO interface register block, top level
// Register front end, locality arbiter, STS FSM, data buffers, interrupts
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_fifo_if
#(
	parameter int CMD_DEPTH = 64,
	parameter int RSP_DEPTH = 64
)
(
	input  logic                         clock,
	input  logic                         reset_n,
	input  tpm_pkg::bus_req_t            bus_i,
	output tpm_pkg::byte_t               rd_data_o,
	output tpm_pkg::loc_onehot_t         locality_o,
	output logic                         pirq_n_o,
	output logic                         exec_start_o,
	output logic [31:0]                  cmd_size_o,
	input  logic [$clog2(CMD_DEPTH)-1:0] cmd_addr_i,
	output tpm_pkg::byte_t               cmd_byte_o,
	input  logic                         rsp_wr_i,
	input  tpm_pkg::byte_t               rsp_byte_i,
	input  logic                         exec_done_i
);

	tpm_pkg::reg_sel_t   sel;
	tpm_pkg::loc_t       active_loc;
	tpm_pkg::sts_state_t sts_state;
	tpm_pkg::byte_t      access_rd;
	tpm_pkg::byte_t      sts_rd;
	tpm_pkg::byte_t      int_rd;
	tpm_pkg::byte_t      rsp_rd;
	logic                wr;
	logic                rd;
	logic                fifo_wr;
	logic                fifo_rd;
	logic                active_valid;
	logic                loc_changed;
	logic                seize;
	logic                data_avail;
	logic                command_ready;
	logic                cmd_complete;
	logic                rsp_empty;

	// Data window strobes
	assign fifo_wr = sel.fifo & wr;
	assign fifo_rd = sel.fifo & rd;

	tpm_reg_space u_reg_space (
		.clock(clock), .reset_n(reset_n), .bus_i(bus_i),
		.active_loc_i(active_loc), .active_valid_i(active_valid),
		.access_rd_i(access_rd), .sts_rd_i(sts_rd), .int_rd_i(int_rd),
		.rsp_rd_i(rsp_rd), .data_avail_i(data_avail),
		.sel_o(sel), .wr_o(wr), .rd_o(rd), .rd_data_o(rd_data_o)
	);

	tpm_locality_arbiter u_arbiter (
		.clock(clock), .reset_n(reset_n), .sel_i(sel), .wr_i(wr), .bus_i(bus_i),
		.active_loc_o(active_loc), .active_valid_o(active_valid), .locality_o(locality_o),
		.loc_changed_o(loc_changed), .seize_o(seize), .access_rd_o(access_rd)
	);

	tpm_sts_fsm u_sts (
		.clock(clock), .reset_n(reset_n), .sel_i(sel), .wr_i(wr), .rd_i(rd), .bus_i(bus_i),
		.seize_i(seize), .fifo_wr_i(fifo_wr), .cmd_complete_i(cmd_complete),
		.rsp_empty_i(rsp_empty), .exec_done_i(exec_done_i),
		.state_o(sts_state), .expect_o(), .data_avail_o(data_avail),
		.command_ready_o(command_ready), .exec_start_o(exec_start_o), .sts_rd_o(sts_rd)
	);

	tpm_data_fifo #(.CMD_DEPTH(CMD_DEPTH), .RSP_DEPTH(RSP_DEPTH)) u_data_fifo (
		.clock(clock), .reset_n(reset_n), .wr_i(fifo_wr), .rd_i(fifo_rd), .bus_i(bus_i),
		.sts_i(sts_state), .cmd_addr_i(cmd_addr_i), .rsp_wr_i(rsp_wr_i),
		.rsp_byte_i(rsp_byte_i), .cmd_complete_o(cmd_complete), .cmd_size_o(cmd_size_o),
		.cmd_byte_o(cmd_byte_o), .rsp_empty_o(rsp_empty), .rsp_rd_o(rsp_rd)
	);

	tpm_int_ctrl u_int_ctrl (
		.clock(clock), .reset_n(reset_n), .sel_i(sel), .wr_i(wr), .bus_i(bus_i),
		.command_ready_i(command_ready), .data_avail_i(data_avail),
		.loc_changed_i(loc_changed), .pirq_n_o(pirq_n_o), .int_rd_o(int_rd)
	);

endmodule

`default_nettype wire

// File: hw/tpm_reg_space.sv
////////////////////////////////////////////////////////////////////////////
// Register space front end
// Offset decode, locality gating, read mux and the registered read byte
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_reg_space
(
	input  logic              clock,
	input  logic              reset_n,
	input  tpm_pkg::bus_req_t bus_i,
	input  tpm_pkg::loc_t     active_loc_i,
	input  logic              active_valid_i,
	input  tpm_pkg::byte_t    access_rd_i,
	input  tpm_pkg::byte_t    sts_rd_i,
	input  tpm_pkg::byte_t    int_rd_i,
	input  tpm_pkg::byte_t    rsp_rd_i,
	input  logic              data_avail_i,
	output tpm_pkg::reg_sel_t sel_o,
	output logic              wr_o,
	output logic              rd_o,
	output tpm_pkg::byte_t    rd_data_o
);

	tpm_pkg::reg_sel_t sel;
	tpm_pkg::reg_off_t off;
	tpm_pkg::byte_t    rd_byte;
	tpm_pkg::byte_t    rd_data_q;
	logic [31:0]       id_word;
	logic              granted;
	logic              allowed;

	assign off     = bus_i.off;
	assign id_word = {tpm_pkg::DID, tpm_pkg::VID}; // VID in the low bytes

	// Dword windows, ACCESS and RID are single bytes
	assign sel.access     = off == tpm_pkg::OFF_ACCESS;
	assign sel.int_enable = off[11:2] == tpm_pkg::OFF_INT_ENABLE[11:2];
	assign sel.int_status = off[11:2] == tpm_pkg::OFF_INT_STATUS[11:2];
	assign sel.sts        = off[11:2] == tpm_pkg::OFF_STS[11:2];
	assign sel.fifo       = (off[11:2] == tpm_pkg::OFF_FIFO[11:2]) |
		(off[11:2] == tpm_pkg::OFF_XFIFO[11:2]);
	assign sel.capability = off[11:2] == tpm_pkg::OFF_INTF_CAP[11:2];
	assign sel.id         = (off[11:2] == tpm_pkg::OFF_DID_VID[11:2]) | (off == tpm_pkg::OFF_RID);
	assign sel.none       = ~|{sel.access, sel.int_enable, sel.int_status, sel.sts,
		sel.fifo, sel.capability, sel.id};

	// Only the active locality gets past, except on ACCESS
	assign granted = active_valid_i & (bus_i.loc == active_loc_i);
	assign allowed = ~sel.none & (sel.access ? (bus_i.loc <= 3'd4) : granted);
	assign wr_o    = bus_i.strobe & ~bus_i.dir & allowed;
	assign rd_o    = bus_i.strobe & bus_i.dir & allowed;
	assign sel_o   = sel;

	always_comb
	begin
		rd_byte = 8'hFF;
		if (sel.access)
			rd_byte = access_rd_i;
		else if (sel.int_enable | sel.int_status)
			rd_byte = int_rd_i;
		else if (sel.sts)
			rd_byte = sts_rd_i;
		else if (sel.fifo & data_avail_i)
			rd_byte = rsp_rd_i;                 // No data, 0xFF
		else if (sel.capability)
			rd_byte = tpm_pkg::INTF_CAP[{off[1:0], 3'b000} +: 8];
		else if (sel.id)
			rd_byte = off[2] ? tpm_pkg::RID : id_word[{off[1:0], 3'b000} +: 8];
	end

	// Read byte one cycle after the strobe
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			rd_data_q <= 8'hFF;
		else
			rd_data_q <= rd_o ? rd_byte : 8'hFF;
	end

	assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: hw/tpm_int_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Interrupt control
// TPM_INT_ENABLE and TPM_INT_STATUS, source edge detect, PIRQ
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_int_ctrl
(
	input  logic              clock,
	input  logic              reset_n,
	input  tpm_pkg::reg_sel_t sel_i,
	input  logic              wr_i,
	input  tpm_pkg::bus_req_t bus_i,
	input  logic              command_ready_i,
	input  logic              data_avail_i,
	input  logic              loc_changed_i,
	output logic              pirq_n_o,
	output tpm_pkg::byte_t    int_rd_o
);

	// Source order {commandReady, locality change, dataAvail}
	logic       gie_q;        // globalIntEnable
	logic [2:0] en_q;
	logic [2:0] flag_q;       // Occurred flags
	logic [2:0] src;
	logic [2:0] src_q;
	logic [2:0] wbits;        // Write byte bits 7, 2 and 0
	logic [2:0] rbits;
	logic       en_wr;
	logic       st_wr;

	assign src   = {command_ready_i, loc_changed_i, data_avail_i};
	assign wbits = {bus_i.wdata[7], bus_i.wdata[2], bus_i.wdata[0]};
	assign en_wr = sel_i.int_enable & wr_i;
	assign st_wr = sel_i.int_status & wr_i & (bus_i.off[1:0] == 2'd0);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			gie_q  <= 1'b0;
			en_q   <= '0;
			flag_q <= '0;
			src_q  <= '0;
		end
		else
		begin
			src_q <= src;
			if (en_wr & (bus_i.off[1:0] == 2'd3))
				gie_q <= bus_i.wdata[7];
			if (en_wr & (bus_i.off[1:0] == 2'd0))
				en_q <= wbits;
			// Write 1 to clear, new rising edges still land
			flag_q <= (flag_q & ~(st_wr ? wbits : 3'b000)) | (src & ~src_q & en_q & {3{gie_q}});
		end
	end

	assign pirq_n_o = ~|flag_q;
	assign rbits    = sel_i.int_status ? flag_q : en_q;

	always_comb
	begin
		case (bus_i.off[1:0])
			2'd0:    int_rd_o = {rbits[2], 4'h0, rbits[1], 1'b0, rbits[0]};
			2'd3:    int_rd_o = {gie_q & sel_i.int_enable, 7'h00};
			default: int_rd_o = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/tpm_data_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Command and response buffers behind the data FIFO window
// Byte counting, header size capture, response pop
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_data_fifo
#(
	parameter int CMD_DEPTH = 64,
	parameter int RSP_DEPTH = 64
)
(
	input  logic                         clock,
	input  logic                         reset_n,
	input  logic                         wr_i,      // FIFO write, locality checked
	input  logic                         rd_i,      // FIFO read, locality checked
	input  tpm_pkg::bus_req_t            bus_i,
	input  tpm_pkg::sts_state_t          sts_i,
	input  logic [$clog2(CMD_DEPTH)-1:0] cmd_addr_i,
	input  logic                         rsp_wr_i,
	input  tpm_pkg::byte_t               rsp_byte_i,
	output logic                         cmd_complete_o,
	output logic [31:0]                  cmd_size_o,
	output tpm_pkg::byte_t               cmd_byte_o,
	output logic                         rsp_empty_o,
	output tpm_pkg::byte_t               rsp_rd_o
);

	localparam int CAW = $clog2(CMD_DEPTH);
	localparam int RAW = $clog2(RSP_DEPTH);

	tpm_pkg::byte_t cmd_mem [CMD_DEPTH];
	tpm_pkg::byte_t rsp_mem [RSP_DEPTH];
	logic [CAW:0]   cmd_cnt_q;
	logic [31:0]    cmd_size_q;   // Big-endian header size
	logic [RAW-1:0] rsp_wp_q;
	logic [RAW-1:0] rsp_rp_q;
	logic [RAW:0]   rsp_cnt_q;
	logic           clear;
	logic           cmd_wr;
	logic           hdr_size;
	logic           rsp_push;
	logic           rsp_pop;

	assign clear    = sts_i == tpm_pkg::STS_IDLE; // Empty again before Ready
	assign cmd_wr   = wr_i & ~cmd_complete_o & (int'(cmd_cnt_q) < CMD_DEPTH) &
		((sts_i == tpm_pkg::STS_READY) | (sts_i == tpm_pkg::STS_RECEPTION));
	assign hdr_size = cmd_cnt_q inside {[2:5]};   // paramSize bytes
	assign rsp_push = rsp_wr_i & ~clear & (int'(rsp_cnt_q) < RSP_DEPTH);
	assign rsp_pop  = rd_i & ~rsp_empty_o & (sts_i == tpm_pkg::STS_COMPLETION);

	// Complete only once the whole header is in
	assign cmd_complete_o = (int'(cmd_cnt_q) > 5) & (32'(cmd_cnt_q) == cmd_size_q);

	always_ff @(posedge clock)
	begin
		if (cmd_wr)
			cmd_mem[cmd_cnt_q[CAW-1:0]] <= bus_i.wdata;
		if (rsp_push)
			rsp_mem[rsp_wp_q] <= rsp_byte_i;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_cnt_q  <= '0;
			cmd_size_q <= '0;
			rsp_wp_q   <= '0;
			rsp_rp_q   <= '0;
			rsp_cnt_q  <= '0;
		end
		else if (clear)
		begin
			cmd_cnt_q  <= '0;
			cmd_size_q <= '0;
			rsp_wp_q   <= '0;
			rsp_rp_q   <= '0;
			rsp_cnt_q  <= '0;
		end
		else
		begin
			if (cmd_wr)
				cmd_cnt_q <= cmd_cnt_q + 1'b1;
			if (cmd_wr & hdr_size)
				cmd_size_q <= {cmd_size_q[23:0], bus_i.wdata};
			// Wrapping pointers, depth need not be a power of two
			if (rsp_push)
				rsp_wp_q <= (int'(rsp_wp_q) == RSP_DEPTH - 1) ? '0 : rsp_wp_q + 1'b1;
			if (rsp_pop)
				rsp_rp_q <= (int'(rsp_rp_q) == RSP_DEPTH - 1) ? '0 : rsp_rp_q + 1'b1;
			rsp_cnt_q <= rsp_cnt_q + {{RAW{1'b0}}, rsp_push} - {{RAW{1'b0}}, rsp_pop};
		end
	end

	assign cmd_size_o  = cmd_size_q;
	assign cmd_byte_o  = cmd_mem[cmd_addr_i];  // Executor side, combinational
	assign rsp_empty_o = rsp_cnt_q == '0;
	assign rsp_rd_o    = rsp_empty_o ? 8'hFF : rsp_mem[rsp_rp_q];

endmodule

`default_nettype wire

// File: hw/tpm_sts_fsm.sv
////////////////////////////////////////////////////////////////////////////
// TPM_STS command state machine
// commandReady and tpmGo strobes, Expect, dataAvail, exec start pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_sts_fsm
(
	input  logic                clock,
	input  logic                reset_n,
	input  tpm_pkg::reg_sel_t   sel_i,
	input  logic                wr_i,
	input  logic                rd_i,
	input  tpm_pkg::bus_req_t   bus_i,
	input  logic                seize_i,
	input  logic                fifo_wr_i,
	input  logic                cmd_complete_i,
	input  logic                rsp_empty_i,
	input  logic                exec_done_i,
	output tpm_pkg::sts_state_t state_o,
	output logic                expect_o,
	output logic                data_avail_o,
	output logic                command_ready_o,
	output logic                exec_start_o,
	output tpm_pkg::byte_t      sts_rd_o
);

	tpm_pkg::sts_state_t state_q;
	logic                sts_wr;
	logic                cmd_ready_wr;
	logic                go_ok;
	logic                avail_q;      // Response phase open
	logic                exec_start_q;

	assign sts_wr       = sel_i.sts & wr_i & (bus_i.off[1:0] == 2'd0);
	assign cmd_ready_wr = sts_wr & bus_i.wdata[6];
	// tpmGo accepted, commandReady or a seize in the same cycle wins
	assign go_ok        = sts_wr & bus_i.wdata[5] & cmd_complete_i & ~bus_i.wdata[6] &
		~seize_i & (state_q == tpm_pkg::STS_RECEPTION);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state_q      <= tpm_pkg::STS_IDLE;
			avail_q      <= 1'b0;
			exec_start_q <= 1'b0;
		end
		else
		begin
			exec_start_q <= go_ok;
			if (seize_i)
				state_q <= tpm_pkg::STS_IDLE;
			else
			begin
				case (state_q)
					tpm_pkg::STS_IDLE:
						if (cmd_ready_wr)
							state_q <= tpm_pkg::STS_READY;
					tpm_pkg::STS_READY:
						if (fifo_wr_i)
							state_q <= tpm_pkg::STS_RECEPTION; // First command byte
					tpm_pkg::STS_RECEPTION:
						if (cmd_ready_wr)
							state_q <= tpm_pkg::STS_IDLE;
						else if (go_ok)
							state_q <= tpm_pkg::STS_EXECUTION;
					tpm_pkg::STS_EXECUTION:
						if (cmd_ready_wr)
							state_q <= tpm_pkg::STS_IDLE;
						else if (exec_done_i)
							state_q <= tpm_pkg::STS_COMPLETION;
					default:
						if (cmd_ready_wr)
							state_q <= tpm_pkg::STS_IDLE;
				endcase
			end
			// Opens on exec done, closes on abort or a read past the last byte
			if (seize_i | cmd_ready_wr)
				avail_q <= 1'b0;
			else if (exec_done_i & (state_q == tpm_pkg::STS_EXECUTION))
				avail_q <= 1'b1;
			else if (sel_i.fifo & rd_i & rsp_empty_i)
				avail_q <= 1'b0;
		end
	end

	assign state_o         = state_q;
	assign expect_o        = (state_q == tpm_pkg::STS_RECEPTION) & ~cmd_complete_i;
	assign data_avail_o    = avail_q & ~rsp_empty_i;
	assign command_ready_o = state_q == tpm_pkg::STS_READY;
	assign exec_start_o    = exec_start_q;

	always_comb
	begin
		case (bus_i.off[1:0])
			2'd0:    sts_rd_o = {1'b1, command_ready_o, 1'b0, data_avail_o, expect_o, 3'b000};
			2'd1:    sts_rd_o = tpm_pkg::BURST_COUNT[7:0];
			2'd2:    sts_rd_o = tpm_pkg::BURST_COUNT[15:8];
			default: sts_rd_o = {4'h0, tpm_pkg::TPM_FAMILY, 2'b00};
		endcase
	end

endmodule

`default_nettype wire

// File: hw/tpm_locality_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Locality arbiter
// Request, seize and beenSeized flags per locality, grant FSM
// and the TPM_ACCESS read byte
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tpm_locality_arbiter
(
	input  logic                 clock,
	input  logic                 reset_n,
	input  tpm_pkg::reg_sel_t    sel_i,
	input  logic                 wr_i,
	input  tpm_pkg::bus_req_t    bus_i,
	output tpm_pkg::loc_t        active_loc_o,
	output logic                 active_valid_o,
	output tpm_pkg::loc_onehot_t locality_o,
	output logic                 loc_changed_o,
	output logic                 seize_o,
	output tpm_pkg::byte_t       access_rd_o
);

	tpm_pkg::loc_state_t  state_q;
	tpm_pkg::loc_t        active_q;
	tpm_pkg::loc_onehot_t req_q;       // requestUse
	tpm_pkg::loc_onehot_t seized_q;    // beenSeized
	tpm_pkg::loc_onehot_t bus_mask;    // Locality of this transaction
	tpm_pkg::loc_onehot_t active_mask;
	tpm_pkg::loc_onehot_t grant_mask;
	tpm_pkg::loc_onehot_t req_set;
	tpm_pkg::loc_onehot_t req_clr;
	tpm_pkg::loc_onehot_t seized_clr;
	tpm_pkg::loc_t        grant_loc;
	logic                 grant_any;
	logic                 acc_wr;
	logic                 relinquish;

	assign bus_mask    = (bus_i.loc <= 3'd4) ? (5'b00001 << bus_i.loc) : 5'b00000;
	assign active_mask = (state_q == tpm_pkg::LOC_ACTIVE) ? (5'b00001 << active_q) : 5'b00000;
	assign grant_mask  = grant_any ? (5'b00001 << grant_loc) : 5'b00000;

	assign acc_wr     = sel_i.access & wr_i; // ACCESS is open to all localities
	assign relinquish = acc_wr & bus_i.wdata[5] & |(active_mask & bus_mask);
	// Seize only from above the active locality
	assign seize_o    = acc_wr & bus_i.wdata[3] & (state_q == tpm_pkg::LOC_ACTIVE) &
		(bus_i.loc > active_q) & (bus_i.loc <= 3'd4);

	assign req_set    = (acc_wr & (bus_i.wdata[1] | bus_i.wdata[3])) ? bus_mask : '0;
	assign req_clr    = ((state_q == tpm_pkg::LOC_RELINQUISH) ? grant_mask : '0) |
		(relinquish ? bus_mask : '0);
	assign seized_clr = (acc_wr & bus_i.wdata[4]) ? bus_mask : '0;

	// Highest pending request wins
	always_comb
	begin
		grant_loc = '0;
		grant_any = 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			if (req_q[i])
			begin
				grant_loc = tpm_pkg::loc_t'(i);
				grant_any = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state_q  <= tpm_pkg::LOC_NONE;
			active_q <= '0;
			req_q    <= '0;
			seized_q <= '0;
		end
		else
		begin
			case (state_q)
				tpm_pkg::LOC_NONE:
					if (|req_q)
						state_q <= tpm_pkg::LOC_RELINQUISH;
				tpm_pkg::LOC_RELINQUISH:
				begin
					state_q  <= grant_any ? tpm_pkg::LOC_ACTIVE : tpm_pkg::LOC_NONE;
					active_q <= grant_loc;
				end
				default:
					if (relinquish | seize_o)
						state_q <= tpm_pkg::LOC_RELINQUISH;
			endcase
			req_q    <= (req_q & ~req_clr) | req_set;      // A new request beats the clear
			seized_q <= (seized_q & ~seized_clr) | (seize_o ? active_mask : '0);
		end
	end

	assign active_loc_o   = active_q;
	assign active_valid_o = state_q == tpm_pkg::LOC_ACTIVE;
	assign locality_o     = active_mask;
	assign loc_changed_o  = state_q == tpm_pkg::LOC_RELINQUISH;

	// Seen by the locality of the read
	assign access_rd_o = {
		state_q != tpm_pkg::LOC_RELINQUISH, // tpmRegValidSts
		1'b0,
		|(active_mask & bus_mask),          // activeLocality
		|(seized_q & bus_mask),
		1'b0,
		|req_q,                             // pendingRequest
		|(req_q & bus_mask),
		1'b1                                // tpmEstablishment
	};

endmodule

`default_nettype wire

// File: hw/tpm_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types for the TPM FIFO register block
// Bus transaction and register select structs, FSM state enums
// Register offsets, identity and capability constants
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package tpm_pkg;

	typedef logic [7:0]  byte_t;       // One data byte
	typedef logic [2:0]  loc_t;        // Locality number, 0 to 4
	typedef logic [4:0]  loc_onehot_t; // One bit per locality
	typedef logic [11:0] reg_off_t;    // Offset inside a locality page

	// One host transaction, a single byte
	typedef struct packed {
		logic     strobe;
		logic     dir;    // 1 = read
		loc_t     loc;
		reg_off_t off;
		byte_t    wdata;
	} bus_req_t;

	typedef enum logic [2:0] {
		STS_IDLE,
		STS_READY,
		STS_RECEPTION,
		STS_EXECUTION,
		STS_COMPLETION
	} sts_state_t;

	typedef enum logic [1:0] {
		LOC_NONE,
		LOC_RELINQUISH,
		LOC_ACTIVE
	} loc_state_t;

	// Decoded register window, one hot
	typedef struct packed {
		logic access;
		logic int_enable;
		logic int_status;
		logic sts;
		logic fifo;
		logic capability;
		logic id;
		logic none;
	} reg_sel_t;

	// Base offsets, four byte registers except ACCESS and RID
	localparam reg_off_t OFF_ACCESS     = 12'h000;
	localparam reg_off_t OFF_INT_ENABLE = 12'h008;
	localparam reg_off_t OFF_INT_STATUS = 12'h010;
	localparam reg_off_t OFF_INTF_CAP   = 12'h014;
	localparam reg_off_t OFF_STS        = 12'h018;
	localparam reg_off_t OFF_FIFO       = 12'h024;
	localparam reg_off_t OFF_XFIFO      = 12'h080; // XData FIFO alias
	localparam reg_off_t OFF_DID_VID    = 12'hF00;
	localparam reg_off_t OFF_RID        = 12'hF04;

	localparam logic [15:0] DID         = 16'h5654;
	localparam logic [15:0] VID         = 16'h3037;
	localparam byte_t       RID         = 8'hFF;
	localparam logic [1:0]  TPM_FAMILY  = 2'b01;    // TPM 2.0
	localparam logic [15:0] BURST_COUNT = 16'h0040; // Static burst

	// Interface 1.3, 64 byte transfers, static burst, level low and falling edge,
	// commandReady, locality change and dataAvail interrupts
	localparam logic [31:0] INTF_CAP    = 32'h3000_07D5;

endpackage

`default_nettype wire
